// File: include/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// architectural register count, x0 included
`define OOO_NUM_REGS 32

// data path width
`define OOO_XLEN 32

// reorder buffer entries, also the in-flight limit
`define OOO_ROB_DEPTH 8

// must equal log2 of the reorder buffer depth
`define OOO_TAG_W 3

// cycles from issue packet to writeback packet
`define OOO_ALU_LAT 2

`endif

// File: design/ooo_pkg.sv
`include "ooo_settings.svh"

package ooo_pkg;

    // architectural register index
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;

    // one data word
    typedef logic [`OOO_XLEN-1:0] xlen_t;

    // reorder buffer entry index
    typedef logic [`OOO_TAG_W-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LI
    } alu_op_e;

    // decoded instruction from the front end
    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
    } instr_t;

    // resolved operands on their way to the ALU
    typedef struct packed {
        alu_op_e  op;
        xlen_t    a;
        xlen_t    b;
        rob_tag_t tag;
    } issue_pkt_t;

    typedef struct packed {
        rob_tag_t tag;
        xlen_t    value;
    } wb_pkt_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    value;
        rob_tag_t tag;
    } commit_t;

endpackage

// File: design/regfile_scoreboard.sv
`timescale 1ns/100ps

`include "ooo_settings.svh"

module regfile_scoreboard (
    input  logic             clk,
    input  logic             rst,

    // operand read ports
    input  ooo_pkg::reg_idx_t rs1,
    input  ooo_pkg::reg_idx_t rs2,
    output ooo_pkg::xlen_t    rs1_value,
    output ooo_pkg::xlen_t    rs2_value,
    output logic              rs1_busy,
    output logic              rs2_busy,
    output ooo_pkg::rob_tag_t rs1_tag,
    output ooo_pkg::rob_tag_t rs2_tag,

    // destination mark from issue
    input  logic              mark,
    input  ooo_pkg::reg_idx_t mark_rd,
    input  ooo_pkg::rob_tag_t mark_tag,

    // in-order commit from the reorder buffer
    input  logic              commit_valid,
    input  ooo_pkg::commit_t  commit
);

    import ooo_pkg::*;

    xlen_t    regs     [`OOO_NUM_REGS];
    rob_tag_t sb_tag   [`OOO_NUM_REGS];
    logic     sb_valid [`OOO_NUM_REGS];

    // x0 reads as zero and never reports a producer
    always_comb begin
        rs1_value = (rs1 == '0) ? '0 : regs[rs1];
        rs2_value = (rs2 == '0) ? '0 : regs[rs2];
        rs1_busy  = (rs1 != '0) && sb_valid[rs1];
        rs2_busy  = (rs2 != '0) && sb_valid[rs2];
        rs1_tag   = sb_tag[rs1];
        rs2_tag   = sb_tag[rs2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i]     <= '0;
                sb_tag[i]   <= '0;
                sb_valid[i] <= 1'b0;
            end
        end else begin
            if (commit_valid && (commit.rd != '0)) begin
                regs[commit.rd] <= commit.value;
                // a younger writer may own the mark by now
                if (sb_valid[commit.rd] && (sb_tag[commit.rd] == commit.tag)) begin
                    sb_valid[commit.rd] <= 1'b0;
                end
            end

            // later assignment, so a same-cycle issue keeps the register busy
            if (mark && (mark_rd != '0)) begin
                sb_tag[mark_rd]   <= mark_tag;
                sb_valid[mark_rd] <= 1'b1;
            end
        end
    end

endmodule

// File: design/issue_stage.sv
`timescale 1ns/100ps

module issue_stage (
    input  logic                clk,
    input  logic                rst,

    input  logic                instr_valid,
    input  ooo_pkg::instr_t     instr,
    output logic                issue_stall,

    // register file and scoreboard
    output ooo_pkg::reg_idx_t   rs1,
    output ooo_pkg::reg_idx_t   rs2,
    input  ooo_pkg::xlen_t      rs1_value,
    input  ooo_pkg::xlen_t      rs2_value,
    input  logic                rs1_busy,
    input  logic                rs2_busy,
    input  ooo_pkg::rob_tag_t   rs1_tag,
    input  ooo_pkg::rob_tag_t   rs2_tag,

    // reorder buffer operand lookup
    output ooo_pkg::rob_tag_t   q1_tag,
    output ooo_pkg::rob_tag_t   q2_tag,
    input  logic                q1_done,
    input  logic                q2_done,
    input  ooo_pkg::xlen_t      q1_value,
    input  ooo_pkg::xlen_t      q2_value,

    // allocation
    input  logic                rob_full,
    output logic                alloc,
    output ooo_pkg::reg_idx_t   alloc_rd,
    input  ooo_pkg::rob_tag_t   alloc_tag,

    output logic                issue_valid,
    output ooo_pkg::issue_pkt_t issue_pkt
);

    import ooo_pkg::*;

    logic  use_imm;
    logic  a_wait;
    logic  b_wait;
    xlen_t a_value;
    xlen_t b_value;

    assign rs1    = instr.rs1;
    assign rs2    = instr.rs2;
    assign q1_tag = rs1_tag;
    assign q2_tag = rs2_tag;

    // load immediate takes b from the instruction, rs2 is ignored
    assign use_imm = (instr.op == OP_LI);

    // busy operand whose producer has not written back yet
    assign a_wait = rs1_busy && !q1_done;
    assign b_wait = !use_imm && rs2_busy && !q2_done;

    always_comb begin
        a_value = rs1_busy ? q1_value : rs1_value;
        if (use_imm) begin
            b_value = instr.imm;
        end else begin
            b_value = rs2_busy ? q2_value : rs2_value;
        end
    end

    assign issue_stall = instr_valid && (rob_full || a_wait || b_wait);
    assign alloc       = instr_valid && !issue_stall;
    assign alloc_rd    = instr.rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= alloc;
        end
    end

    // issue packet, loaded on acceptance
    always_ff @(posedge clk) begin
        if (alloc) begin
            issue_pkt.op  <= instr.op;
            issue_pkt.a   <= a_value;
            issue_pkt.b   <= b_value;
            issue_pkt.tag <= alloc_tag;
        end
    end

endmodule

// File: design/alu_pipe.sv
`timescale 1ns/100ps

`include "ooo_settings.svh"

module alu_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  ooo_pkg::issue_pkt_t issue_pkt,
    output logic                wb_valid,
    output ooo_pkg::wb_pkt_t    wb_pkt
);

    import ooo_pkg::*;

    // stages after the compute stage
    localparam int HOLD = `OOO_ALU_LAT - 1;

    xlen_t           result;
    logic            s1_valid;
    wb_pkt_t         s1_pkt;
    logic [HOLD-1:0] hold_valid;
    wb_pkt_t         hold_pkt [HOLD];

    always_comb begin
        unique case (issue_pkt.op)
            OP_ADD:  result = issue_pkt.a + issue_pkt.b;
            OP_SUB:  result = issue_pkt.a - issue_pkt.b;
            OP_AND:  result = issue_pkt.a & issue_pkt.b;
            OP_OR:   result = issue_pkt.a | issue_pkt.b;
            OP_XOR:  result = issue_pkt.a ^ issue_pkt.b;
            OP_LI:   result = issue_pkt.b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            hold_valid <= '0;
        end else begin
            s1_valid <= issue_valid;
            for (int i = 0; i < HOLD; i++) begin
                hold_valid[i] <= (i == 0) ? s1_valid : hold_valid[i-1];
            end
        end
    end

    // results move every cycle, the ALU never stalls
    always_ff @(posedge clk) begin
        s1_pkt.tag   <= issue_pkt.tag;
        s1_pkt.value <= result;
        for (int i = 0; i < HOLD; i++) begin
            hold_pkt[i] <= (i == 0) ? s1_pkt : hold_pkt[i-1];
        end
    end

    assign wb_valid = hold_valid[HOLD-1];
    assign wb_pkt   = hold_pkt[HOLD-1];

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/100ps

`include "ooo_settings.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,

    // allocation at the tail
    input  logic              alloc,
    input  ooo_pkg::reg_idx_t alloc_rd,
    output ooo_pkg::rob_tag_t alloc_tag,
    output logic              rob_full,

    // operand lookup by tag
    input  ooo_pkg::rob_tag_t q1_tag,
    input  ooo_pkg::rob_tag_t q2_tag,
    output logic              q1_done,
    output logic              q2_done,
    output ooo_pkg::xlen_t    q1_value,
    output ooo_pkg::xlen_t    q2_value,

    // writeback from the ALU
    input  logic              wb_valid,
    input  ooo_pkg::wb_pkt_t  wb_pkt,

    output logic              commit_valid,
    output ooo_pkg::commit_t  commit
);

    import ooo_pkg::*;

    rob_tag_t               head;
    rob_tag_t               tail;
    logic [`OOO_TAG_W:0]    count;

    logic  [`OOO_ROB_DEPTH-1:0] ent_busy;
    logic  [`OOO_ROB_DEPTH-1:0] ent_done;
    reg_idx_t               ent_rd    [`OOO_ROB_DEPTH];
    xlen_t                  ent_value [`OOO_ROB_DEPTH];

    assign alloc_tag = tail;
    assign rob_full  = (count == (`OOO_TAG_W+1)'(`OOO_ROB_DEPTH));

    // a stale tag points at a done or freed entry, the scoreboard filters it
    assign q1_done  = ent_busy[q1_tag] && ent_done[q1_tag];
    assign q2_done  = ent_busy[q2_tag] && ent_done[q2_tag];
    assign q1_value = ent_value[q1_tag];
    assign q2_value = ent_value[q2_tag];

    // head leaves as soon as its result is in
    assign commit_valid = ent_busy[head] && ent_done[head];
    assign commit.rd    = ent_rd[head];
    assign commit.value = ent_value[head];
    assign commit.tag   = head;

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_busy <= '0;
            ent_done <= '0;
        end else begin
            if (alloc) begin
                ent_busy[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end

            if (wb_valid) begin
                ent_done[wb_pkt.tag] <= 1'b1;
            end

            // full blocks alloc, so the freed head never meets the tail here
            if (commit_valid) begin
                ent_busy[head] <= 1'b0;
                ent_done[head] <= 1'b0;
                head           <= head + 1'b1;
            end

            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload, kept until the entry is reused
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_rd[tail] <= alloc_rd;
        end
        if (wb_valid) begin
            ent_value[wb_pkt.tag] <= wb_pkt.value;
        end
    end

endmodule

// File: design/ooo_core.sv
`timescale 1ns/100ps

module ooo_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  ooo_pkg::instr_t  instr,
    output logic             issue_stall,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit
);

    import ooo_pkg::*;

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      rs1_value;
    xlen_t      rs2_value;
    logic       rs1_busy;
    logic       rs2_busy;
    rob_tag_t   rs1_tag;
    rob_tag_t   rs2_tag;

    rob_tag_t   q1_tag;
    rob_tag_t   q2_tag;
    logic       q1_done;
    logic       q2_done;
    xlen_t      q1_value;
    xlen_t      q2_value;

    logic       rob_full;
    logic       alloc;
    reg_idx_t   alloc_rd;
    rob_tag_t   alloc_tag;

    logic       issue_valid;
    issue_pkt_t issue_pkt;
    logic       wb_valid;
    wb_pkt_t    wb_pkt;

    issue_stage issue_stage_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .issue_stall (issue_stall),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .rs1_busy    (rs1_busy),
        .rs2_busy    (rs2_busy),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .q1_tag      (q1_tag),
        .q2_tag      (q2_tag),
        .q1_done     (q1_done),
        .q2_done     (q2_done),
        .q1_value    (q1_value),
        .q2_value    (q2_value),
        .rob_full    (rob_full),
        .alloc       (alloc),
        .alloc_rd    (alloc_rd),
        .alloc_tag   (alloc_tag),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt)
    );

    // the scoreboard mark is the reorder buffer allocation itself
    regfile_scoreboard regfile_scoreboard_i (
        .clk          (clk),
        .rst          (rst),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .rs1_busy     (rs1_busy),
        .rs2_busy     (rs2_busy),
        .rs1_tag      (rs1_tag),
        .rs2_tag      (rs2_tag),
        .mark         (alloc),
        .mark_rd      (alloc_rd),
        .mark_tag     (alloc_tag),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    alu_pipe alu_pipe_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .wb_valid    (wb_valid),
        .wb_pkt      (wb_pkt)
    );

    reorder_buffer reorder_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alloc_rd     (alloc_rd),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .q1_tag       (q1_tag),
        .q2_tag       (q2_tag),
        .q1_done      (q1_done),
        .q2_done      (q2_done),
        .q1_value     (q1_value),
        .q2_value     (q2_value),
        .wb_valid     (wb_valid),
        .wb_pkt       (wb_pkt),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // held high across the first rising edges, released on an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: test/ooo_core_asserts.sv
`timescale 1ns/100ps

`include "ooo_settings.svh"

module ooo_core_asserts (
    input logic                      clk,
    input logic                      rst,
    input logic                      alloc,
    input logic                      rob_full,
    input logic                      wb_valid,
    input ooo_pkg::wb_pkt_t          wb_pkt,
    input logic [`OOO_ROB_DEPTH-1:0] ent_busy,
    input logic                      commit_valid
);

    // nothing may commit straight out of reset
    commit_quiet_after_reset: assert property (
        @(posedge clk) rst |=> !commit_valid
    ) else $error("commit_valid high in the cycle after reset");

    // a result must land on a live entry
    wb_to_busy_entry: assert property (
        @(posedge clk) disable iff (rst) wb_valid |-> ent_busy[wb_pkt.tag]
    ) else $error("writeback to reorder buffer entry %0d which is not busy", wb_pkt.tag);

    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst) alloc |-> !rob_full
    ) else $error("allocation while the reorder buffer is full");

endmodule

// File: test/tb_ooo_core.sv
`timescale 1ns/100ps

`include "ooo_settings.svh"

module tb_ooo_core;

    import ooo_pkg::*;

    // instructions issued by each test
    localparam int RESET_INSTRS    = `OOO_NUM_REGS;
    localparam int INDEP_INSTRS    = 10;
    localparam int RAW_INSTRS      = 14;
    localparam int X0_INSTRS       = 8;
    localparam int STREAM_INSTRS   = 200;
    localparam int TOTAL_INSTRS    = RESET_INSTRS + INDEP_INSTRS + RAW_INSTRS + X0_INSTRS
                                     + STREAM_INSTRS;
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_INSTRS;
    // a full buffer empties well within this
    localparam int DRAIN_CYCLES    = 4 * `OOO_ROB_DEPTH;

    logic    clk;
    logic    rst;
    logic    instr_valid;
    instr_t  instr;
    logic    issue_stall;
    logic    commit_valid;
    commit_t commit;

    // reference state
    xlen_t    arch_regs [`OOO_NUM_REGS];
    rob_tag_t next_tag;
    commit_t  exp_q [$];
    commit_t  expected_c;

    string       test_name = "reset";
    int          stall_cycles;
    logic [31:0] lfsr_state = 32'h080cf201;

    tb_clock #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (2)
    ) tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    ooo_core ooo_core_i (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .issue_stall  (issue_stall),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    bind reorder_buffer ooo_core_asserts rob_asserts_i (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .rob_full     (rob_full),
        .wb_valid     (wb_valid),
        .wb_pkt       (wb_pkt),
        .ent_busy     (ent_busy),
        .commit_valid (commit_valid)
    );

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic instr_t make_instr(input alu_op_e op, input int rd, input int rs1,
                                          input int rs2, input xlen_t imm);
        instr_t ins;
        ins.op  = op;
        ins.rd  = reg_idx_t'(rd);
        ins.rs1 = reg_idx_t'(rs1);
        ins.rs2 = reg_idx_t'(rs2);
        ins.imm = imm;
        return ins;
    endfunction

    // sequential architectural model, one instruction at a time
    function automatic commit_t ref_commit(input instr_t ins);
        commit_t c;
        xlen_t   a;
        xlen_t   b;
        xlen_t   r;
        a = (ins.rs1 == '0) ? '0 : arch_regs[ins.rs1];
        if (ins.op == OP_LI) begin
            b = ins.imm;
        end else begin
            b = (ins.rs2 == '0) ? '0 : arch_regs[ins.rs2];
        end
        case (ins.op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_LI:   r = b;
            default: r = '0;
        endcase
        if (ins.rd != '0) begin
            arch_regs[ins.rd] = r;
        end
        c.rd     = ins.rd;
        c.value  = r;
        c.tag    = next_tag;
        next_tag = next_tag + rob_tag_t'(1);
        return c;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_commit(input string name, input commit_t exp, input commit_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected rd=%0d value=%h tag=%0d, actual rd=%0d value=%h tag=%0d",
                     name, exp.rd, exp.value, exp.tag, act.rd, act.value, act.tag);
            abort_run();
        end
    endtask

    task automatic check_stall_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: issue_stall expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // present an instruction and hold it until accepted
    task automatic issue_instr(input instr_t ins, input bit check_stall, input logic exp_stall);
        instr_valid <= 1'b1;
        instr       <= ins;
        @(posedge clk);
        if (check_stall) begin
            check_stall_level(test_name, exp_stall, issue_stall);
        end
        while (issue_stall) begin
            stall_cycles++;
            @(posedge clk);
        end
        exp_q.push_back(ref_commit(ins));
    endtask

    task automatic idle(input int cycles);
        instr_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    // wait for every outstanding commit, bounded by the buffer depth
    task automatic drain();
        int waited;
        waited = 0;
        instr_valid <= 1'b0;
        while ((exp_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
            waited++;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected commits never arrived in %s", exp_q.size(), test_name);
            abort_run();
        end else begin
            @(posedge clk);
        end
    endtask

    // compare every commit against the reference queue
    always @(posedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("commit of rd %0d arrived with no instruction outstanding", commit.rd);
                abort_run();
            end else begin
                expected_c = exp_q.pop_front();
                check_commit(test_name, expected_c, commit);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        int prev_rd;
        int rd;
        instr_valid <= 1'b0;
        instr       <= '0;
        next_tag     = '0;
        stall_cycles = 0;
        foreach (arch_regs[i]) begin
            arch_regs[i] = '0;
        end

        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        check_stall_level(test_name, 1'b0, issue_stall);

        // every register reads zero out of reset
        test_name = "reset_state";
        for (int n = 0; n < RESET_INSTRS; n++) begin
            issue_instr(make_instr(OP_ADD, n, n, 0, '0), 1'b1, 1'b0);
        end
        drain();

        test_name = "independent_ops";
        for (int i = 0; i < 5; i++) begin
            issue_instr(make_instr(OP_LI, 10 + i, 0, 0, take_bits(32)), 1'b1, 1'b0);
        end
        drain();
        issue_instr(make_instr(OP_ADD, 15, 10, 11, '0), 1'b1, 1'b0);
        issue_instr(make_instr(OP_SUB, 16, 12, 13, '0), 1'b1, 1'b0);
        issue_instr(make_instr(OP_AND, 17, 14, 10, '0), 1'b1, 1'b0);
        issue_instr(make_instr(OP_OR, 18, 11, 12, '0), 1'b1, 1'b0);
        issue_instr(make_instr(OP_XOR, 19, 13, 14, '0), 1'b1, 1'b0);
        drain();

        // each consumer sits right behind its producer
        test_name = "raw_chain";
        issue_instr(make_instr(OP_LI, 1, 0, 0, take_bits(16)), 1'b1, 1'b0);
        issue_instr(make_instr(OP_ADD, 2, 1, 1, '0), 1'b1, 1'b1);
        issue_instr(make_instr(OP_SUB, 3, 2, 1, '0), 1'b1, 1'b1);
        issue_instr(make_instr(OP_XOR, 4, 3, 2, '0), 1'b1, 1'b1);
        issue_instr(make_instr(OP_AND, 5, 4, 3, '0), 1'b1, 1'b1);
        prev_rd = 5;
        for (int i = 0; i < 8; i++) begin
            rd = 1 + int'(take_bits(4));
            issue_instr(make_instr(alu_op_e'(3'(take_bits(3) % 32'd5)), rd, prev_rd,
                                   1 + int'(take_bits(4)), '0), 1'b0, 1'b0);
            prev_rd = rd;
        end
        drain();
        // sources now come from the register file
        issue_instr(make_instr(OP_OR, 9, 4, 1, '0), 1'b1, 1'b0);
        drain();

        test_name = "x0_writes";
        issue_instr(make_instr(OP_LI, 0, 0, 0, take_bits(32)), 1'b1, 1'b0);
        issue_instr(make_instr(OP_ADD, 0, 1, 2, '0), 1'b1, 1'b0);
        issue_instr(make_instr(OP_ADD, 6, 0, 0, '0), 1'b1, 1'b0);
        // three writers in flight, the youngest must win
        issue_instr(make_instr(OP_LI, 7, 0, 0, take_bits(32)), 1'b0, 1'b0);
        issue_instr(make_instr(OP_LI, 7, 0, 0, take_bits(32)), 1'b1, 1'b0);
        issue_instr(make_instr(OP_LI, 7, 0, 0, take_bits(32)), 1'b1, 1'b0);
        issue_instr(make_instr(OP_ADD, 8, 7, 0, '0), 1'b1, 1'b1);
        drain();
        issue_instr(make_instr(OP_ADD, 10, 7, 0, '0), 1'b1, 1'b0);
        drain();

        // rs1 is random, so a busy one stalls even though the value ignores it
        test_name = "li_stream";
        stall_cycles = 0;
        for (int i = 0; i < STREAM_INSTRS; i++) begin
            rd = 1 + int'(take_bits(3));
            issue_instr(make_instr(OP_LI, rd, int'(take_bits(3)), int'(take_bits(5)),
                                   take_bits(32)), 1'b0, 1'b0);
            if (take_bits(2) == 32'd0) begin
                idle(1);
            end
        end
        drain();
        // extra commits would show up here
        idle(10);

        if (stall_cycles == 0) begin
            $display("issue_stall never rose during the instruction stream");
            abort_run();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+include
design/ooo_pkg.sv
design/regfile_scoreboard.sv
design/issue_stage.sv
design/alu_pipe.sv
design/reorder_buffer.sv
design/ooo_core.sv
test/tb_clock.sv
test/ooo_core_asserts.sv
test/tb_ooo_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_ooo_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := NO ERRORS

.PHONY: sim clean

# the pipeline status is the status of grep, so a missing pass line fails
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
